/* rtl/board_defs.svh */
// Board constants for the 125 MHz front end; RATE and N must stay >= 2, switch count is fixed at 4
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// Number of user switches on the board
`define BRD_SW_W 4

// Flop depth of the input synchronizers
`define BRD_SYNC_STAGES 2

// Cycles the system reset is held after the clock manager locks
`define BRD_RST_STAGES 4

// Consecutive agreeing samples before a switch output moves
`define BRD_DEBOUNCE_N 4

// Clock cycles between switch samples
// 125000 cycles at 125 MHz gives a 1 ms sample period
`define BRD_DEBOUNCE_RATE 125000

`endif

/* rtl/board_pkg.sv */
// Shared board types; the switch vector width follows BRD_SW_W and the status pairs are fixed
`default_nettype none

`include "board_defs.svh"

package board_pkg;

    // One bit per user switch, bit 0 is switch 0
    typedef logic [`BRD_SW_W-1:0] sw_t;

    // UART control lines from the USB bridge
    typedef struct packed {
        // Serial data toward the FPGA
        logic txd;
        // Request to send from the host
        logic rts;
    } uart_ctrl_t;

    // Status pins of the external jitter-cleaner PLL
    typedef struct packed {
        // Interrupt, active low
        logic intr_n;
        // Loss of lock, active low
        logic lol_n;
    } pll_status_t;

endpackage

`default_nettype wire

/* rtl/sync_signal.sv */
// Plain multi-flop synchronizer; safe only for levels or payloads where a one-cycle skew is harmless
`timescale 1ns/1ps
`default_nettype none

module sync_signal #(
    // Payload type, any packed type
    parameter type T = logic,
    // Value all stages take during reset
    parameter T RESET_VAL = '0,
    // Number of flops in the chain, at least 1
    parameter int STAGES = 2
) (
    input  wire logic clk_125mhz_i,
    input  wire logic arst_n_i,
    input  T          data_i,
    output T          data_o
);

    // Synchronizer chain, stage 0 sees the raw input
    T sync_q [STAGES];

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= RESET_VAL;
            end
        end else begin
            sync_q[0] <= data_i;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign data_o = sync_q[STAGES-1];

endmodule

`default_nettype wire

/* rtl/switch_debounce.sv */
// Switch debouncer; inputs are sampled raw, so a short glitch can still land in one sample
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module switch_debounce #(
    // Clock cycles between samples, at least 2
    parameter int RATE = `BRD_DEBOUNCE_RATE
) (
    input  wire logic     clk_125mhz_i,
    input  wire logic     arst_n_i,
    input  board_pkg::sw_t sw_i,
    output board_pkg::sw_t sw_o
);

    localparam int CNT_W = (RATE > 1) ? $clog2(RATE) : 1;

    // Sample-rate divider
    logic [CNT_W-1:0] cnt_q;
    logic             sample;

    // Per-switch sample history, newest sample in bit 0
    logic [`BRD_DEBOUNCE_N-1:0] hist_q [`BRD_SW_W];

    // Debounced state
    board_pkg::sw_t sw_q;

    // Strobe on the last count of each period
    assign sample = (cnt_q == CNT_W'(RATE - 1));

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (sample) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Shift each switch into its own history on the strobe
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `BRD_SW_W; i++) begin
                hist_q[i] <= '0;
            end
        end else if (sample) begin
            for (int i = 0; i < `BRD_SW_W; i++) begin
                hist_q[i] <= {hist_q[i][`BRD_DEBOUNCE_N-2:0], sw_i[i]};
            end
        end
    end

    // Output moves only on a unanimous history, otherwise holds
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sw_q <= '0;
        end else begin
            for (int i = 0; i < `BRD_SW_W; i++) begin
                if (&hist_q[i]) begin
                    sw_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    sw_q[i] <= 1'b0;
                end
            end
        end
    end

    assign sw_o = sw_q;

endmodule

`default_nettype wire

/* rtl/reset_ctrl.sv */
// Reset control; pll_status_i must already be synchronized, and lock loss resets asynchronously
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module reset_ctrl (
    input  wire logic           clk_125mhz_i,
    input  wire logic           arst_n_i,
    input  board_pkg::pll_status_t pll_status_i,
    input  wire logic           pll_i2c_busy_i,
    input  wire logic           mmcm_locked_i,
    output wire logic           mmcm_rst_o,
    output wire logic           rst_125mhz_o
);

    // Clock manager reset request
    logic mmcm_rst_q;

    // Release stretcher, ones shift out after lock
    logic [`BRD_RST_STAGES-1:0] rst_sr_q;

    // Stretcher clears on either board reset or lock loss
    logic rst_src_n;

    // Hold the clock manager in reset while the PLL is being
    // programmed or has lost its input reference.
    // The interrupt pin is not a reset cause
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mmcm_rst_q <= 1'b0;
        end else begin
            mmcm_rst_q <= pll_i2c_busy_i || !pll_status_i.lol_n;
        end
    end

    assign rst_src_n = arst_n_i && mmcm_locked_i;

    // Assert at once, release BRD_RST_STAGES edges after lock
    always_ff @(posedge clk_125mhz_i or negedge rst_src_n) begin
        if (!rst_src_n) begin
            rst_sr_q <= '1;
        end else begin
            rst_sr_q <= rst_sr_q << 1;
        end
    end

    assign mmcm_rst_o   = mmcm_rst_q;
    assign rst_125mhz_o = rst_sr_q[`BRD_RST_STAGES-1];

endmodule

`default_nettype wire

/* rtl/board_frontend.sv */
// Board front end in the 125 MHz domain; clock manager lock and I2C busy arrive as plain inputs
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_frontend #(
    // Debounce sample period in clock cycles
    parameter int DEBOUNCE_RATE = `BRD_DEBOUNCE_RATE
) (
    input  wire logic              clk_125mhz_i,
    input  wire logic              arst_n_i,

    // Clock manager and PLL init
    input  wire logic              mmcm_locked_i,
    input  wire logic              pll_i2c_busy_i,
    input  board_pkg::pll_status_t pll_status_i,
    output wire logic              mmcm_rst_o,
    output wire logic              rst_125mhz_o,

    // UART control from the USB bridge
    input  board_pkg::uart_ctrl_t  uart_ctrl_i,
    output board_pkg::uart_ctrl_t  uart_ctrl_o,

    // User switches
    input  board_pkg::sw_t         sw_i,
    output board_pkg::sw_t         sw_o
);

    // PLL pins idle high, so reset must not look like lock loss
    localparam board_pkg::pll_status_t PLL_STATUS_RST = '{intr_n: 1'b1, lol_n: 1'b1};

    // UART lines idle with txd high
    localparam board_pkg::uart_ctrl_t UART_CTRL_RST = '{txd: 1'b1, rts: 1'b0};

    board_pkg::pll_status_t pll_status_sync;

    sync_signal #(
        .T         (board_pkg::pll_status_t),
        .RESET_VAL (PLL_STATUS_RST),
        .STAGES    (`BRD_SYNC_STAGES)
    ) pll_status_sync_inst (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .data_i       (pll_status_i),
        .data_o       (pll_status_sync)
    );

    reset_ctrl reset_ctrl_inst (
        .clk_125mhz_i   (clk_125mhz_i),
        .arst_n_i       (arst_n_i),
        .pll_status_i   (pll_status_sync),
        .pll_i2c_busy_i (pll_i2c_busy_i),
        .mmcm_locked_i  (mmcm_locked_i),
        .mmcm_rst_o     (mmcm_rst_o),
        .rst_125mhz_o   (rst_125mhz_o)
    );

    sync_signal #(
        .T         (board_pkg::uart_ctrl_t),
        .RESET_VAL (UART_CTRL_RST),
        .STAGES    (`BRD_SYNC_STAGES)
    ) uart_ctrl_sync_inst (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .data_i       (uart_ctrl_i),
        .data_o       (uart_ctrl_o)
    );

    switch_debounce #(
        .RATE (DEBOUNCE_RATE)
    ) switch_debounce_inst (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .sw_i         (sw_i),
        .sw_o         (sw_o)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// Free-running testbench clock that starts low; the period must be an even number of ns
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    // Clock period in ns
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* dv/board_frontend_chk.sv */
// Bound into the front end; the busy property is only checked once lol_n has been high 3 cycles
`timescale 1ns/1ps
`default_nettype none

module board_frontend_chk (
    input wire logic              clk_125mhz_i,
    input wire logic              arst_n_i,
    input wire logic              mmcm_locked_i,
    input wire logic              pll_i2c_busy_i,
    input board_pkg::pll_status_t pll_status_i,
    input board_pkg::uart_ctrl_t  uart_ctrl_i,
    input board_pkg::uart_ctrl_t  uart_ctrl_o,
    input wire logic              mmcm_rst_o,
    input wire logic              rst_125mhz_o
);

    // System reset covers every unlocked cycle
    rst_while_unlocked: assert property (
        @(posedge clk_125mhz_i) disable iff (!arst_n_i)
        !mmcm_locked_i |-> rst_125mhz_o
    ) else $error("rst_125mhz_o low while the clock manager is unlocked");

    // With lol_n quiet, the request is busy delayed by one edge
    busy_to_request: assert property (
        @(posedge clk_125mhz_i) disable iff (!arst_n_i)
        ($past(pll_status_i.lol_n, 1) && $past(pll_status_i.lol_n, 2)
            && $past(pll_status_i.lol_n, 3))
        |-> (mmcm_rst_o == $past(pll_i2c_busy_i))
    ) else $error("mmcm_rst_o does not follow pll_i2c_busy_i by one cycle");

    // Two-flop synchronizer latency
    uart_two_cycles: assert property (
        @(posedge clk_125mhz_i) disable iff (!arst_n_i)
        uart_ctrl_o == $past(uart_ctrl_i, 2)
    ) else $error("uart_ctrl_o is not uart_ctrl_i from two cycles earlier");

endmodule

bind board_frontend board_frontend_chk chk_inst (
    .clk_125mhz_i   (clk_125mhz_i),
    .arst_n_i       (arst_n_i),
    .mmcm_locked_i  (mmcm_locked_i),
    .pll_i2c_busy_i (pll_i2c_busy_i),
    .pll_status_i   (pll_status_i),
    .uart_ctrl_i    (uart_ctrl_i),
    .uart_ctrl_o    (uart_ctrl_o),
    .mmcm_rst_o     (mmcm_rst_o),
    .rst_125mhz_o   (rst_125mhz_o)
);

`default_nettype wire

/* dv/board_frontend_tb.sv */
// Directed tests at a debounce rate of 8 cycles; needs a timing-capable simulator, stops at first error
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_frontend_tb;

    localparam int RATE = 8;
    // Tests need about 600 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    // N+1 sample periods plus output register slack
    localparam int SW_SETTLE = (`BRD_DEBOUNCE_N + 1) * RATE + 2;

    logic                   clk;
    logic                   arst_n;
    logic                   mmcm_locked;
    logic                   pll_i2c_busy;
    board_pkg::pll_status_t pll_status;
    board_pkg::uart_ctrl_t  uart_in;
    board_pkg::sw_t         sw_in;
    logic                   mmcm_rst;
    logic                   rst_125mhz;
    board_pkg::uart_ctrl_t  uart_out;
    board_pkg::sw_t         sw_out;

    int seed = 32'h7044;
    int cycle_cnt = 0;

    tb_clk_gen #(.PERIOD_NS(100)) clk_gen_inst (.clk_o(clk));

    board_frontend #(
        .DEBOUNCE_RATE (RATE)
    ) DUT (
        .clk_125mhz_i   (clk),
        .arst_n_i       (arst_n),
        .mmcm_locked_i  (mmcm_locked),
        .pll_i2c_busy_i (pll_i2c_busy),
        .pll_status_i   (pll_status),
        .mmcm_rst_o     (mmcm_rst),
        .rst_125mhz_o   (rst_125mhz),
        .uart_ctrl_i    (uart_in),
        .uart_ctrl_o    (uart_out),
        .sw_i           (sw_in),
        .sw_o           (sw_out)
    );

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped on a failed check");
    endtask

    task automatic bit_compare(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: at %0d ns %s expected %b actual %b", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic uart_compare(input string name, input board_pkg::uart_ctrl_t exp,
                                input board_pkg::uart_ctrl_t act);
        if (act !== exp) begin
            $display("error: at %0d ns %s expected %b actual %b", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic sw_compare(input string name, input board_pkg::sw_t exp,
                              input board_pkg::sw_t act);
        if (act !== exp) begin
            $display("error: at %0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    // Drive point sits 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic after_reset_test();
        bit_compare("rst_125mhz_o", 1'b1, rst_125mhz);
        bit_compare("mmcm_rst_o", 1'b0, mmcm_rst);
        sw_compare("sw_o", '0, sw_out);
        uart_compare("uart_ctrl_o", '{txd: 1'b1, rts: 1'b0}, uart_out);
    endtask

    // Raise lock and expect release on exactly the 4th edge
    task automatic lock_release();
        mmcm_locked = 1'b1;
        for (int k = 1; k <= `BRD_RST_STAGES + 2; k++) begin
            next_cycle();
            bit_compare("rst_125mhz_o", (k < `BRD_RST_STAGES), rst_125mhz);
        end
    endtask

    task automatic reset_release_test();
        next_cycle();
        bit_compare("rst_125mhz_o", 1'b1, rst_125mhz);
        lock_release();
        // Lock loss asserts reset without waiting for an edge
        mmcm_locked = 1'b0;
        #1;
        bit_compare("rst_125mhz_o", 1'b1, rst_125mhz);
        next_cycle();
        bit_compare("rst_125mhz_o", 1'b1, rst_125mhz);
        lock_release();
    endtask

    task automatic reset_request_test();
        logic busy_pat [40];
        logic lol_pat [40];
        logic exp;
        for (int i = 0; i < 40; i++) begin
            busy_pat[i] = (i >= 5 && i < 8) || (i == 30);
            lol_pat[i] = !(i >= 20 && i < 22);
        end
        for (int i = 0; i < 40; i++) begin
            pll_i2c_busy = busy_pat[i];
            pll_status.lol_n = lol_pat[i];
            next_cycle();
            // Busy shows after 1 edge, lol_n after 3
            exp = busy_pat[i] || (i >= 2 && !lol_pat[i-2]);
            bit_compare("mmcm_rst_o", exp, mmcm_rst);
        end
    endtask

    task automatic uart_sync_test();
        board_pkg::uart_ctrl_t sent [$];
        logic [31:0] rnd;
        sent.push_back(uart_in);
        for (int i = 0; i < 22; i++) begin
            if (i < 20) begin
                rnd = $random(seed);
                uart_in = rnd[1:0];
            end
            sent.push_back(uart_in);
            next_cycle();
            uart_compare("uart_ctrl_o", sent[sent.size()-2], uart_out);
        end
    endtask

    task automatic debounce_test();
        board_pkg::sw_t sw_cur;
        board_pkg::sw_t sw_new;
        board_pkg::sw_t flip;
        board_pkg::sw_t moved;
        logic [31:0] rnd;
        int waited;
        int pulse_len [3] = '{16, 9, 3};
        sw_cur = '0;
        for (int k = 0; k < 3; k++) begin
            rnd = $random(seed);
            sw_new = rnd[`BRD_SW_W-1:0];
            if (sw_new == sw_cur) begin
                sw_new = ~sw_cur;
            end
            sw_in = sw_new;
            waited = 0;
            while (sw_out != sw_new && waited < SW_SETTLE) begin
                next_cycle();
                waited++;
                moved = (sw_out ^ sw_cur) & ~(sw_new ^ sw_cur);
                if (moved != '0) begin
                    $display("sw_o changed a bit whose switch input stayed the same");
                    stop_with_failure();
                end
            end
            sw_compare("sw_o", sw_new, sw_out);
            sw_cur = sw_new;
            repeat (RATE) begin
                next_cycle();
                sw_compare("sw_o", sw_cur, sw_out);
            end
        end
        // Short pulses reach at most two samples
        for (int k = 0; k < 3; k++) begin
            rnd = $random(seed);
            flip = rnd[`BRD_SW_W-1:0];
            if (flip == '0) begin
                flip = '1;
            end
            sw_in = sw_cur ^ flip;
            repeat (pulse_len[k]) begin
                next_cycle();
                sw_compare("sw_o", sw_cur, sw_out);
            end
            sw_in = sw_cur;
            repeat (5 * RATE) begin
                next_cycle();
                sw_compare("sw_o", sw_cur, sw_out);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    initial begin
        arst_n = 1'b1;
        mmcm_locked = 1'b1;
        pll_i2c_busy = 1'b0;
        pll_status = '{intr_n: 1'b1, lol_n: 1'b1};
        uart_in = '{txd: 1'b1, rts: 1'b0};
        sw_in = '0;
        // Real falling edges so the async resets fire
        #5;
        arst_n = 1'b0;
        mmcm_locked = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        arst_n = 1'b1;
        after_reset_test();
        reset_release_test();
        reset_request_test();
        uart_sync_test();
        debounce_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* board_frontend.f */
+incdir+rtl
rtl/board_pkg.sv
rtl/sync_signal.sv
rtl/switch_debounce.sv
rtl/reset_ctrl.sv
rtl/board_frontend.sv
dv/tb_clk_gen.sv
dv/board_frontend_chk.sv
dv/board_frontend_tb.sv

/* Makefile */
# Verilator simulation of the board front end
VERILATOR ?= verilator
TOP       ?= board_frontend_tb
FILELIST  ?= board_frontend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
